//--- cpu_pkg.sv
package cpu_pkg;

	localparam int word_w = 8;
	localparam int addr_w = 14;

	// T-state codes as they appear on the state pins
	typedef enum logic [2:0] {
		ts_wait    = 3'b000,
		ts_t3      = 3'b001,
		ts_t1      = 3'b010,
		ts_stopped = 3'b011,
		ts_t2      = 3'b100,
		ts_t5      = 3'b101,
		ts_t4      = 3'b111
	} t_state_e;

	typedef enum logic [1:0] {
		cyc_pci = 2'b00,
		cyc_pcr = 2'b01,
		cyc_pcc = 2'b10
	} cycle_type_e;

	typedef enum logic [1:0] {
		mc_first,
		mc_second,
		mc_third
	} mcycle_e;

	typedef enum logic [2:0] {
		reg_a, reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_mem
	} reg_idx_e;

	typedef enum logic [2:0] {
		alu_add, alu_adc, alu_sub, alu_sbb, alu_and, alu_xor, alu_or, alu_cmp
	} alu_op_e;

	typedef enum logic [1:0] {
		rot_rlc, rot_rrc, rot_ral, rot_rar
	} rot_op_e;

	typedef struct packed {
		logic carry;
		logic zero;
		logic sign;
		logic parity;
	} flags_t;

	typedef struct packed {
		logic [1:0] group;
		reg_idx_e   ddd;
		reg_idx_e   sss;
	} move_view_t;

	typedef struct packed {
		logic [1:0] group;
		alu_op_e    alu_op;
		reg_idx_e   src;
	} operate_view_t;

	// One opcode byte, read as a move or as an operate instruction
	typedef union packed {
		move_view_t    mv;
		operate_view_t op;
	} instr_u;

	typedef enum logic [2:0] {
		src_none, src_pc_lo, src_pc_hi, src_reg, src_alu, src_tmp_a, src_tmp_b, src_d_in
	} bus_src_e;

	typedef struct packed {
		bus_src_e    bus_src;
		reg_idx_e    rf_sel;
		logic        rf_we;
		logic        ir_load;
		logic        tmp_a_load;
		logic        tmp_b_load;
		alu_op_e     alu_op;
		rot_op_e     rot_op;
		logic        alu_rot;
		logic        alu_inc_dec;
		logic        flag_we;
		logic        pc_inc;
		logic        pc_load_lo;
		logic        pc_load_hi;
		cycle_type_e cycle_type;
	} ctrl_t;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu_pkg::ctrl_t              ctrl,
	input  logic [cpu_pkg::word_w-1:0]  a,
	input  logic [cpu_pkg::word_w-1:0]  b,
	output logic [cpu_pkg::word_w-1:0]  result,
	output cpu_pkg::flags_t             flags
);

	cpu_pkg::flags_t            flag_in;
	logic                       carry_out;
	logic [cpu_pkg::word_w-1:0] diff;
	logic [cpu_pkg::word_w-1:0] zsp_val;

	always_comb begin
		result = '0;
		{carry_out, diff} = {1'b0, a} - {1'b0, b};
		zsp_val = '0;
		flag_in = flags;
		if (ctrl.alu_rot) begin
			case (ctrl.rot_op)
				cpu_pkg::rot_rlc: {carry_out, result} = {a[7], a[6:0], a[7]};
				cpu_pkg::rot_rrc: {carry_out, result} = {a[0], a[0], a[7:1]};
				cpu_pkg::rot_ral: {carry_out, result} = {a, flags.carry};
				default:          {carry_out, result} = {a[0], flags.carry, a[7:1]};
			endcase
			flag_in.carry = carry_out;
		end else begin
			if (ctrl.alu_inc_dec) begin
				result = (ctrl.alu_op == cpu_pkg::alu_sub) ? b - 8'd1 : b + 8'd1;
				carry_out = flags.carry;
			end else begin
				case (ctrl.alu_op)
					cpu_pkg::alu_add: {carry_out, result} = {1'b0, a} + {1'b0, b};
					cpu_pkg::alu_adc: {carry_out, result} = {1'b0, a} + {1'b0, b} + 9'(flags.carry);
					cpu_pkg::alu_sub: {carry_out, result} = {1'b0, a} - {1'b0, b};
					cpu_pkg::alu_sbb: {carry_out, result} = {1'b0, a} - {1'b0, b} - 9'(flags.carry);
					cpu_pkg::alu_and: {carry_out, result} = {1'b0, a & b};
					cpu_pkg::alu_xor: {carry_out, result} = {1'b0, a ^ b};
					cpu_pkg::alu_or:  {carry_out, result} = {1'b0, a | b};
					default:          result = a;
				endcase
			end
			// Compare leaves A alone and sets the flags from the difference
			zsp_val = (!ctrl.alu_inc_dec && ctrl.alu_op == cpu_pkg::alu_cmp) ? diff : result;
			flag_in.carry = carry_out;
			flag_in.zero = ~(|zsp_val);
			flag_in.sign = zsp_val[7];
			flag_in.parity = ~(^zsp_val);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			flags <= '0;
		else if (ctrl.flag_we)
			flags <= flag_in;
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu_pkg::ctrl_t              ctrl,
	input  logic [cpu_pkg::word_w-1:0]  bus,
	output logic [cpu_pkg::word_w-1:0]  rf_out,
	output logic [cpu_pkg::word_w-1:0]  acc
);

	logic [cpu_pkg::word_w-1:0] regs [0:6];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 7; i++)
				regs[i] <= '0;
		end else if (ctrl.rf_we && ctrl.rf_sel != cpu_pkg::reg_mem) begin
			regs[ctrl.rf_sel] <= bus;
		end
	end

	// Memory operand code reads as zero
	assign rf_out = (ctrl.rf_sel == cpu_pkg::reg_mem) ? '0 : regs[ctrl.rf_sel];
	assign acc = regs[cpu_pkg::reg_a];

endmodule

//--- program_counter.sv
`timescale 1ns/1ps

module program_counter (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu_pkg::ctrl_t              ctrl,
	input  logic [cpu_pkg::word_w-1:0]  bus,
	output logic [cpu_pkg::addr_w-1:0]  pc
);

	logic [cpu_pkg::word_w-1:0] lo_hold;

	// The low target byte waits here so the third JMP byte is still fetched
	// from the incremented address
	always_ff @(posedge clk) begin
		if (ctrl.pc_load_lo)
			lo_hold <= bus;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (ctrl.pc_load_hi)
			pc <= {bus[cpu_pkg::addr_w-9:0], lo_hold};
		else if (ctrl.pc_inc)
			pc <= pc + 1'b1;
	end

endmodule

//--- bus_datapath.sv
`timescale 1ns/1ps

module bus_datapath (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu_pkg::ctrl_t              ctrl,
	input  logic [cpu_pkg::word_w-1:0]  d_in,
	input  logic [cpu_pkg::addr_w-1:0]  pc,
	input  logic [cpu_pkg::word_w-1:0]  rf_out,
	input  logic [cpu_pkg::word_w-1:0]  alu_out,
	input  logic [cpu_pkg::word_w-1:0]  acc,
	output logic [cpu_pkg::word_w-1:0]  bus,
	output cpu_pkg::instr_u             instr,
	output logic [cpu_pkg::word_w-1:0]  tmp_a,
	output logic [cpu_pkg::word_w-1:0]  tmp_b
);

	cpu_pkg::instr_u ir_q;

	always_ff @(posedge clk) begin
		if (rst)
			ir_q <= '0;
		else if (ctrl.ir_load)
			ir_q <= d_in;
	end

	// The opcode is visible during its own T3 so the sequencer can branch on it
	assign instr = ctrl.ir_load ? cpu_pkg::instr_u'(d_in) : ir_q;

	always_ff @(posedge clk) begin
		if (ctrl.tmp_a_load)
			tmp_a <= acc;
		if (ctrl.tmp_b_load)
			tmp_b <= bus;
	end

	always_comb begin
		case (ctrl.bus_src)
			cpu_pkg::src_pc_lo: bus = pc[7:0];
			cpu_pkg::src_pc_hi: bus = {ctrl.cycle_type, pc[cpu_pkg::addr_w-1:8]};
			cpu_pkg::src_reg:   bus = rf_out;
			cpu_pkg::src_alu:   bus = alu_out;
			cpu_pkg::src_tmp_a: bus = tmp_a;
			cpu_pkg::src_tmp_b: bus = tmp_b;
			cpu_pkg::src_d_in:  bus = d_in;
			default:            bus = {ctrl.cycle_type, 6'b000000};
		endcase
	end

endmodule

//--- cycle_control.sv
`timescale 1ns/1ps

module cycle_control (
	input  logic              clk,
	input  logic              rst,
	input  logic              ready,
	input  cpu_pkg::instr_u   instr,
	input  cpu_pkg::flags_t   flags,
	output cpu_pkg::ctrl_t    ctrl,
	output logic              sync,
	output cpu_pkg::t_state_e state
);

	logic              ready_meta;
	logic              ready_s;
	cpu_pkg::mcycle_e  cycle;
	cpu_pkg::mcycle_e  next_cycle;
	cpu_pkg::t_state_e next_state;
	logic [7:0]        opcode;
	logic [1:0]        grp;
	logic              is_hlt;
	logic              is_mov;
	logic              is_alu_r;
	logic              is_alu_i;
	logic              is_mvi;
	logic              is_inc_dec;
	logic              is_rot;
	logic              is_jmp;
	logic              is_out;
	logic              multi;
	cpu_pkg::alu_op_e  eff_op;

	always_ff @(posedge clk) begin
		if (rst) begin
			ready_meta <= 1'b0;
			ready_s <= 1'b0;
		end else begin
			ready_meta <= ready;
			ready_s <= ready_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cpu_pkg::ts_t1;
			cycle <= cpu_pkg::mc_first;
		end else begin
			state <= next_state;
			cycle <= next_cycle;
		end
	end

	assign opcode = instr;
	assign grp = instr.mv.group;
	assign is_hlt = (opcode == 8'h00) || (opcode == 8'h01) || (opcode == 8'hff);
	assign is_mov = (grp == 2'b11) && !is_hlt;
	assign is_alu_r = (grp == 2'b10);
	assign is_mvi = (grp == 2'b00) && (instr.mv.sss == cpu_pkg::reg_l);
	assign is_alu_i = (grp == 2'b00) && (instr.mv.sss == cpu_pkg::reg_e);
	assign is_inc_dec = (grp == 2'b00) && (instr.mv.sss[2:1] == 2'b00) && !is_hlt;
	assign is_rot = (grp == 2'b00) && (instr.mv.sss == cpu_pkg::reg_c) && !instr.mv.ddd[2];
	assign is_jmp = (grp == 2'b01) && (instr.mv.sss == cpu_pkg::reg_e);
	assign is_out = (grp == 2'b01) && instr.mv.sss[0] && (instr.mv.ddd[2:1] != 2'b00);
	assign multi = is_mvi || is_alu_i || is_jmp || is_out;

	// With carry clear, ADC and SBB give the same result and flags as ADD and SUB
	always_comb begin
		eff_op = instr.op.alu_op;
		if (!flags.carry && eff_op == cpu_pkg::alu_adc)
			eff_op = cpu_pkg::alu_add;
		else if (!flags.carry && eff_op == cpu_pkg::alu_sbb)
			eff_op = cpu_pkg::alu_sub;
	end

	assign sync = (state == cpu_pkg::ts_t1) || (state == cpu_pkg::ts_t2);

	always_comb begin
		ctrl = '0;
		next_state = state;
		next_cycle = cycle;
		case (state)
			cpu_pkg::ts_t1: begin
				next_state = cpu_pkg::ts_t2;
				if (cycle != cpu_pkg::mc_first && is_out) begin
					ctrl.bus_src = cpu_pkg::src_reg;
					ctrl.rf_sel = cpu_pkg::reg_a;
				end else begin
					ctrl.bus_src = cpu_pkg::src_pc_lo;
				end
			end
			cpu_pkg::ts_t2: begin
				next_state = ready_s ? cpu_pkg::ts_t3 : cpu_pkg::ts_wait;
				if (cycle == cpu_pkg::mc_first) begin
					ctrl.cycle_type = cpu_pkg::cyc_pci;
					ctrl.bus_src = cpu_pkg::src_pc_hi;
					ctrl.pc_inc = 1'b1;
				end else if (is_out) begin
					// Output cycle shows only the cycle type, address bits stay zero
					ctrl.cycle_type = cpu_pkg::cyc_pcc;
					ctrl.bus_src = cpu_pkg::src_none;
				end else begin
					ctrl.cycle_type = cpu_pkg::cyc_pcr;
					ctrl.bus_src = cpu_pkg::src_pc_hi;
					ctrl.pc_inc = 1'b1;
				end
			end
			cpu_pkg::ts_wait: begin
				next_state = ready_s ? cpu_pkg::ts_t3 : cpu_pkg::ts_wait;
			end
			cpu_pkg::ts_t3: begin
				next_state = cpu_pkg::ts_t1;
				next_cycle = cpu_pkg::mc_first;
				case (cycle)
					cpu_pkg::mc_first: begin
						ctrl.ir_load = 1'b1;
						if (is_hlt)
							next_state = cpu_pkg::ts_stopped;
						else if (multi)
							next_cycle = cpu_pkg::mc_second;
						else
							next_state = cpu_pkg::ts_t4;
					end
					cpu_pkg::mc_second: begin
						if (is_mvi) begin
							ctrl.bus_src = cpu_pkg::src_d_in;
							ctrl.rf_sel = instr.mv.ddd;
							ctrl.rf_we = 1'b1;
						end else if (is_alu_i) begin
							ctrl.bus_src = cpu_pkg::src_d_in;
							ctrl.tmp_a_load = 1'b1;
							ctrl.tmp_b_load = 1'b1;
							next_state = cpu_pkg::ts_t4;
							next_cycle = cpu_pkg::mc_second;
						end else if (is_jmp) begin
							ctrl.bus_src = cpu_pkg::src_d_in;
							ctrl.pc_load_lo = 1'b1;
							next_cycle = cpu_pkg::mc_third;
						end
					end
					default: begin
						ctrl.bus_src = cpu_pkg::src_d_in;
						ctrl.pc_load_hi = 1'b1;
					end
				endcase
			end
			cpu_pkg::ts_t4: begin
				next_state = cpu_pkg::ts_t5;
				if (is_mov || is_alu_r) begin
					ctrl.bus_src = cpu_pkg::src_reg;
					ctrl.rf_sel = instr.mv.sss;
					ctrl.tmp_b_load = 1'b1;
					ctrl.tmp_a_load = is_alu_r;
				end else if (is_inc_dec) begin
					ctrl.bus_src = cpu_pkg::src_reg;
					ctrl.rf_sel = instr.mv.ddd;
					ctrl.tmp_b_load = 1'b1;
				end else if (is_rot) begin
					ctrl.tmp_a_load = 1'b1;
				end
			end
			cpu_pkg::ts_t5: begin
				next_state = cpu_pkg::ts_t1;
				next_cycle = cpu_pkg::mc_first;
				if (is_mov) begin
					ctrl.bus_src = cpu_pkg::src_tmp_b;
					ctrl.rf_sel = instr.mv.ddd;
					ctrl.rf_we = 1'b1;
				end else if (is_alu_r || is_alu_i) begin
					ctrl.bus_src = cpu_pkg::src_alu;
					ctrl.alu_op = eff_op;
					ctrl.rf_sel = cpu_pkg::reg_a;
					ctrl.rf_we = 1'b1;
					ctrl.flag_we = 1'b1;
				end else if (is_inc_dec) begin
					ctrl.bus_src = cpu_pkg::src_alu;
					ctrl.alu_inc_dec = 1'b1;
					ctrl.alu_op = instr.mv.sss[0] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
					ctrl.rf_sel = instr.mv.ddd;
					ctrl.rf_we = 1'b1;
					ctrl.flag_we = 1'b1;
				end else if (is_rot) begin
					ctrl.bus_src = cpu_pkg::src_alu;
					ctrl.alu_rot = 1'b1;
					ctrl.rot_op = cpu_pkg::rot_op_e'(instr.mv.ddd[1:0]);
					ctrl.rf_sel = cpu_pkg::reg_a;
					ctrl.rf_we = 1'b1;
					ctrl.flag_we = 1'b1;
				end
			end
			cpu_pkg::ts_stopped: begin
				next_state = cpu_pkg::ts_stopped;
			end
			default: begin
				next_state = cpu_pkg::ts_t1;
				next_cycle = cpu_pkg::mc_first;
			end
		endcase
	end

endmodule

//--- i8008_core.sv
`timescale 1ns/1ps

module i8008_core (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [cpu_pkg::word_w-1:0]   d_in,
	input  logic                         ready,
	output logic [cpu_pkg::word_w-1:0]   d_out,
	output logic                         sync,
	output cpu_pkg::t_state_e            state
);

	cpu_pkg::ctrl_t              ctrl;
	cpu_pkg::instr_u             instr;
	cpu_pkg::flags_t             flags;
	logic [cpu_pkg::word_w-1:0]  bus;
	logic [cpu_pkg::word_w-1:0]  rf_out;
	logic [cpu_pkg::word_w-1:0]  acc;
	logic [cpu_pkg::word_w-1:0]  tmp_a;
	logic [cpu_pkg::word_w-1:0]  tmp_b;
	logic [cpu_pkg::word_w-1:0]  alu_out;
	logic [cpu_pkg::addr_w-1:0]  pc;

	assign d_out = bus;

	cycle_control u_cycle_control (
		.clk   (clk),
		.rst   (rst),
		.ready (ready),
		.instr (instr),
		.flags (flags),
		.ctrl  (ctrl),
		.sync  (sync),
		.state (state)
	);

	bus_datapath u_bus_datapath (
		.clk     (clk),
		.rst     (rst),
		.ctrl    (ctrl),
		.d_in    (d_in),
		.pc      (pc),
		.rf_out  (rf_out),
		.alu_out (alu_out),
		.acc     (acc),
		.bus     (bus),
		.instr   (instr),
		.tmp_a   (tmp_a),
		.tmp_b   (tmp_b)
	);

	alu u_alu (
		.clk    (clk),
		.rst    (rst),
		.ctrl   (ctrl),
		.a      (tmp_a),
		.b      (tmp_b),
		.result (alu_out),
		.flags  (flags)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.rst    (rst),
		.ctrl   (ctrl),
		.bus    (bus),
		.rf_out (rf_out),
		.acc    (acc)
	);

	program_counter u_program_counter (
		.clk  (clk),
		.rst  (rst),
		.ctrl (ctrl),
		.bus  (bus),
		.pc   (pc)
	);

endmodule

//--- i8008_assertions.sv
`timescale 1ns/1ps

module i8008_assertions (
	input logic              clk,
	input logic              rst,
	input logic              sync,
	input cpu_pkg::t_state_e state
);

	assert property (@(posedge clk) disable iff (rst)
		state inside {cpu_pkg::ts_t1, cpu_pkg::ts_t2, cpu_pkg::ts_wait, cpu_pkg::ts_t3,
			cpu_pkg::ts_t4, cpu_pkg::ts_t5, cpu_pkg::ts_stopped})
		else $error("illegal T-state code %b", state);

	assert property (@(posedge clk) disable iff (rst)
		sync |-> (state == cpu_pkg::ts_t1 || state == cpu_pkg::ts_t2))
		else $error("sync high outside T1 and T2");

	// The only way out of WAIT is T3
	assert property (@(posedge clk) disable iff (rst)
		state == cpu_pkg::ts_wait |=> (state == cpu_pkg::ts_wait || state == cpu_pkg::ts_t3))
		else $error("WAIT left to state %b", state);

	assert property (@(posedge clk) disable iff (rst)
		state == cpu_pkg::ts_stopped |=> state == cpu_pkg::ts_stopped)
		else $error("STOPPED was left without reset");

endmodule

bind cycle_control i8008_assertions u_assertions (
	.clk   (clk),
	.rst   (rst),
	.sync  (sync),
	.state (state)
);

//--- tb_i8008_core.sv
`timescale 1ns/1ps

module tb_i8008_core;

	logic                      clk;
	logic                      rst;
	logic [7:0]                d_in;
	logic                      ready;
	logic [7:0]                d_out;
	logic                      sync;
	cpu_pkg::t_state_e         state;

	logic [7:0]                mem [0:255];
	logic [31:0]               lfsr;
	int                        gen_addr;
	// Each entry is one bus cycle as {T2 byte, T1 byte}
	logic [15:0]               exp_bus [$];
	logic [7:0]                addr_lo;
	logic [7:0]                t1_byte;
	int                        bus_cycles;
	int                        stall_left;
	int                        wait_run;
	int                        max_wait_run;
	logic [2:0]                hist = 3'b111;
	cpu_pkg::t_state_e         prev_state = cpu_pkg::ts_t1;

	i8008_core u_dut (
		.clk   (clk),
		.rst   (rst),
		.d_in  (d_in),
		.ready (ready),
		.d_out (d_out),
		.sync  (sync),
		.state (state)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("Error: %s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [2:0] pick_reg(input bit allow_a);
		logic [2:0] r;
		r = 3'(rand_bits(3));
		while (r == 3'd7 || (!allow_a && r == 3'd0))
			r = 3'(rand_bits(3));
		return r;
	endfunction

	function automatic void emit(input logic [7:0] b);
		mem[gen_addr] = b;
		gen_addr++;
	endfunction

	function automatic void load_program();
		logic [2:0] kind;
		logic [2:0] d;
		logic [2:0] s;
		logic [1:0] port;
		int skip;
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'hc3;
		gen_addr = 0;
		while (gen_addr < 232) begin
			kind = 3'(rand_bits(3));
			d = pick_reg(1'b1);
			s = pick_reg(1'b1);
			case (kind)
				3'd0: begin
					emit({2'b00, d, 3'b110});
					emit(8'(rand_bits(8)));
				end
				3'd1: emit({2'b11, d, s});
				3'd2, 3'd3: emit({2'b10, 3'(rand_bits(3)), s});
				3'd4: begin
					emit({2'b00, 3'(rand_bits(3)), 3'b100});
					emit(8'(rand_bits(8)));
				end
				3'd5: emit({2'b00, pick_reg(1'b0), 2'b00, 1'(rand_bits(1))});
				3'd6: emit({3'b000, 2'(rand_bits(2)), 3'b010});
				default: begin
					// Forward jump over a few HLT bytes with junk in bits 7:6 of its high byte
					skip = 1 + int'(rand_bits(2));
					emit({2'b01, 3'(rand_bits(3)), 3'b100});
					emit(8'(gen_addr + 2 + skip));
					emit({2'(rand_bits(2)), 6'b000000});
					repeat (skip) emit(8'hff);
				end
			endcase
			if (kind != 3'd7) begin
				port = 2'(rand_bits(2));
				if (port == 2'b00)
					port = 2'b11;
				emit({2'b01, port, 1'(rand_bits(1)), 2'(rand_bits(2)), 1'b1});
			end
		end
		emit(8'h00);
	endfunction

	function automatic logic [8:0] alu_ref(input logic [2:0] op, input logic [7:0] a,
			input logic [7:0] b, input logic cin);
		int x;
		int y;
		int c;
		x = int'(a);
		y = int'(b);
		c = int'(cin);
		case (op)
			3'd0: x = x + y;
			3'd1: x = x + y + c;
			3'd2: x = x - y;
			3'd3: x = x - y - c;
			3'd4: return {1'b0, a & b};
			3'd5: return {1'b0, a ^ b};
			3'd6: return {1'b0, a | b};
			default: return {(a < b) ? 1'b1 : 1'b0, a};
		endcase
		// Carry is overflow past 255 on add and borrow on subtract
		return {(x > 255 || x < 0) ? 1'b1 : 1'b0, x[7:0]};
	endfunction

	// Runs the program one instruction at a time and lists every bus cycle
	function automatic void run_reference();
		logic [7:0]  r [0:6];
		logic        cy;
		logic [13:0] pc;
		logic [7:0]  op;
		logic [7:0]  lo;
		logic [7:0]  hi;
		logic [8:0]  res;
		int          steps;
		bit          halted;
		for (int i = 0; i < 7; i++)
			r[i] = 8'h00;
		cy = 1'b0;
		pc = '0;
		halted = 0;
		steps = 0;
		while (!halted && steps < 1000) begin
			exp_bus.push_back({2'b00, pc[13:8], pc[7:0]});
			op = mem[pc[7:0]];
			pc = pc + 14'd1;
			steps++;
			if (op == 8'h00 || op == 8'h01 || op == 8'hff) begin
				halted = 1;
			end else if (op[7:6] == 2'b11) begin
				r[op[5:3]] = r[op[2:0]];
			end else if (op[7:6] == 2'b10) begin
				res = alu_ref(op[5:3], r[0], r[op[2:0]], cy);
				r[0] = res[7:0];
				cy = res[8];
			end else if (op[7:6] == 2'b00 && op[2:1] == 2'b11 && !op[0]) begin
				exp_bus.push_back({2'b01, pc[13:8], pc[7:0]});
				r[op[5:3]] = mem[pc[7:0]];
				pc = pc + 14'd1;
			end else if (op[7:6] == 2'b00 && op[2:0] == 3'b100) begin
				exp_bus.push_back({2'b01, pc[13:8], pc[7:0]});
				res = alu_ref(op[5:3], r[0], mem[pc[7:0]], cy);
				r[0] = res[7:0];
				cy = res[8];
				pc = pc + 14'd1;
			end else if (op[7:6] == 2'b00 && op[2:1] == 2'b00) begin
				r[op[5:3]] = op[0] ? r[op[5:3]] - 8'd1 : r[op[5:3]] + 8'd1;
			end else if (op[7:6] == 2'b00 && op[2:0] == 3'b010 && !op[5]) begin
				lo = r[0];
				case (op[4:3])
					2'b00: r[0] = {lo[6:0], lo[7]};
					2'b01: r[0] = {lo[0], lo[7:1]};
					2'b10: r[0] = {lo[6:0], cy};
					default: r[0] = {cy, lo[7:1]};
				endcase
				cy = op[3] ? lo[0] : lo[7];
			end else if (op[7:6] == 2'b01 && op[2:0] == 3'b100) begin
				exp_bus.push_back({2'b01, pc[13:8], pc[7:0]});
				lo = mem[pc[7:0]];
				pc = pc + 14'd1;
				exp_bus.push_back({2'b01, pc[13:8], pc[7:0]});
				hi = mem[pc[7:0]];
				pc = {hi[5:0], lo};
			end else if (op[7:6] == 2'b01 && op[0] && op[5:4] != 2'b00) begin
				exp_bus.push_back({8'h80, r[0]});
			end
		end
	endfunction

	// The memory model forces one long READY stall once the program is under way
	always @(negedge clk) begin
		if (state == cpu_pkg::ts_t1)
			addr_lo = d_out;
		if (rst) begin
			ready <= 1'b1;
		end else begin
			if (state == cpu_pkg::ts_t2) begin
				d_in <= mem[addr_lo];
				bus_cycles++;
				if (bus_cycles == 40)
					stall_left = 40;
			end
			if (stall_left > 0) begin
				ready <= 1'b0;
				stall_left--;
			end else begin
				ready <= (rand_bits(2) != 32'd0);
			end
		end
	end

	always @(negedge clk) begin
		logic [15:0] expected;
		hist = {hist[1:0], ready};
		// T1 of the first fetch overlaps the release of reset
		if (state == cpu_pkg::ts_t1)
			t1_byte = d_out;
		if (!rst) begin
			check_value("sync", 16'(sync),
				16'(state == cpu_pkg::ts_t1 || state == cpu_pkg::ts_t2));
			if (state == cpu_pkg::ts_t2) begin
				if (exp_bus.size() == 0)
					abort_run("a bus cycle started after the program should have halted");
				expected = exp_bus.pop_front();
				check_value("d_out in T1", 16'(t1_byte), 16'(expected[7:0]));
				check_value("d_out in T2", 16'(d_out), 16'(expected[15:8]));
			end
			if (prev_state == cpu_pkg::ts_wait) begin
				if (state != cpu_pkg::ts_wait && state != cpu_pkg::ts_t3)
					abort_run("WAIT was left for a state other than T3");
				// READY seen low by the synchronizer must hold the core in WAIT
				if (!hist[2])
					check_value("state", 16'(state), 16'(cpu_pkg::ts_wait));
			end
			if (prev_state == cpu_pkg::ts_stopped)
				check_value("state", 16'(state), 16'(cpu_pkg::ts_stopped));
			wait_run = (state == cpu_pkg::ts_wait) ? wait_run + 1 : 0;
			if (wait_run > max_wait_run)
				max_wait_run = wait_run;
		end
		prev_state = state;
	end

	initial begin
		int timeout;
		rst = 1'b1;
		ready = 1'b1;
		d_in = 8'h00;
		bus_cycles = 0;
		stall_left = 0;
		wait_run = 0;
		max_wait_run = 0;
		lfsr = 32'h26224dbc;
		load_program();
		run_reference();
		repeat (16) @(negedge clk);
		rst <= 1'b0;

		timeout = 0;
		while (exp_bus.size() != 0 && timeout < 50000) begin
			@(negedge clk);
			timeout++;
		end
		if (exp_bus.size() != 0)
			abort_run("timed out waiting for the expected bus cycles");

		timeout = 0;
		while (state != cpu_pkg::ts_stopped && timeout < 100) begin
			@(negedge clk);
			timeout++;
		end
		if (state != cpu_pkg::ts_stopped)
			abort_run("the core did not reach STOPPED after HLT");

		repeat (50) begin
			@(negedge clk);
			check_value("sync", 16'(sync), 16'h0000);
		end

		if (max_wait_run < 25) begin
			$display("Error: holding READY low did not keep the core in WAIT");
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

//--- build.f
cpu_pkg.sv
alu.sv
reg_file.sv
program_counter.sv
bus_datapath.sv
cycle_control.sv
i8008_core.sv
i8008_assertions.sv
tb_i8008_core.sv

//--- Makefile
TOP := tb_i8008_core
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)
